// File: logic/cfg_pkg.sv
// Datapath and register file sizes
// Register count, index width, shift amount width

package cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    localparam int DATA_W = 32;                     // Register and result width
    localparam int SHAMT_W = 5;                     // Low operand bits used by shifts

    //////////////////////////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////////////////////////

    localparam int NUM_REGS = 16;
    localparam int REG_ADDR_W = $clog2(NUM_REGS);   // Register index width

endpackage

// File: logic/isa_pkg.sv
// Opcode encoding of the execute engine
// Command and response structs carried over the req/ack handshake

package isa_pkg;

    localparam int IMM_W = 16;                      // Immediate field width

    //////////////////////////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,                              // rs1 + rs2, wrapping
        OP_SUB = 3'd1,                              // rs1 - rs2, wrapping
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,                              // Shift by low bits of rs2
        OP_SRL = 3'd6,                              // Logical, zero fill
        OP_LDI = 3'd7                               // Zero-extended immediate
    } opcode_e;

    //////////////////////////////////////////////////////////////////////
    // Host side payloads
    //////////////////////////////////////////////////////////////////////

    // One command, 31 bits in all
    typedef struct packed {
        opcode_e                         opcode;
        logic [cfg_pkg::REG_ADDR_W-1:0]  rd;        // Destination
        logic [cfg_pkg::REG_ADDR_W-1:0]  rs1;       // First source
        logic [cfg_pkg::REG_ADDR_W-1:0]  rs2;       // Second source
        logic [IMM_W-1:0]                imm;       // Used by LDI only
    } exec_cmd_t;

    // Returned while ack is high
    typedef struct packed {
        logic [cfg_pkg::DATA_W-1:0]      result;
        logic                            zero;      // Result is all zeros
    } exec_rsp_t;

endpackage

// File: logic/mem_dp.sv
// Generic dual-ported memory
// Several combinational read ports, one clocked write port, optional bypass

`timescale 1ns/1ps

module mem_dp #(
    parameter int WIDTH      = 32,
    parameter int DEPTH      = 32,
    parameter int READ_PORTS = 1,
    parameter int BYPASS_EN  = 0    // 1: same-address write seen by reads this cycle
) (
    input  logic                                      clock,
    input  logic                                      reset,

    // Read ports
    input  logic [READ_PORTS-1:0]                     re,
    input  logic [READ_PORTS-1:0][$clog2(DEPTH)-1:0]  raddr,
    output logic [READ_PORTS-1:0][WIDTH-1:0]          rdata,

    // Write port
    input  logic                                      we,
    input  logic [$clog2(DEPTH)-1:0]                  waddr,
    input  logic [WIDTH-1:0]                          wdata
);

    logic [DEPTH-1:0][WIDTH-1:0] mem;               // Storage array

    //////////////////////////////////////////////////////////////////////
    // Read logic
    //////////////////////////////////////////////////////////////////////

    // Each port is independent; disabled ports return zero
    always_comb begin
        for (int p = 0; p < READ_PORTS; p++) begin
            if (!re[p]) begin
                rdata[p] = '0;
            end else if ((BYPASS_EN != 0) && we && (raddr[p] == waddr)) begin
                rdata[p] = wdata;                   // Forward the write in flight
            end else begin
                rdata[p] = mem[raddr[p]];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Write logic
    //////////////////////////////////////////////////////////////////////

    // Whole array clears on reset, so every entry reads as zero until written
    always_ff @(posedge clock) begin
        if (reset) begin
            mem <= '0;
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Assertions
    //////////////////////////////////////////////////////////////////////

    // Write address known and inside the array
    a_waddr_ok: assert property (
        @(posedge clock) disable iff (reset)
        we |-> (!$isunknown(waddr) && (waddr < DEPTH))
    ) else $error("mem_dp: bad write address %h", waddr);

    // Same check per read port, only while that port is enabled
    for (genvar i = 0; i < READ_PORTS; i++) begin : g_read_chk
        a_raddr_ok: assert property (
            @(posedge clock) disable iff (reset)
            re[i] |-> (!$isunknown(raddr[i]) && (raddr[i] < DEPTH))
        ) else $error("mem_dp: bad read address %h on port %0d", raddr[i], i);
    end

endmodule

// File: logic/alu.sv
// Registered arithmetic and logic unit
// Eight opcodes, result and zero flag held until the next load

`timescale 1ns/1ps

module alu (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        load,       // Capture a new result
    input  isa_pkg::opcode_e            op,
    input  logic [cfg_pkg::DATA_W-1:0]  a,          // rs1 value
    input  logic [cfg_pkg::DATA_W-1:0]  b,          // rs2 value
    input  logic [isa_pkg::IMM_W-1:0]   imm,
    output logic [cfg_pkg::DATA_W-1:0]  result,
    output logic                        zero
);

    logic [cfg_pkg::SHAMT_W-1:0]  shamt;            // Shift amount from b
    logic [cfg_pkg::DATA_W-1:0]   result_next;

    assign shamt = b[cfg_pkg::SHAMT_W-1:0];         // Upper bits of b ignored

    //////////////////////////////////////////////////////////////////////
    // Compute
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            isa_pkg::OP_ADD: result_next = a + b;   // Wraps mod 2^DATA_W
            isa_pkg::OP_SUB: result_next = a - b;
            isa_pkg::OP_AND: result_next = a & b;
            isa_pkg::OP_OR:  result_next = a | b;
            isa_pkg::OP_XOR: result_next = a ^ b;
            isa_pkg::OP_SLL: result_next = a << shamt;
            isa_pkg::OP_SRL: result_next = a >> shamt;   // Zero fill
            isa_pkg::OP_LDI: result_next = cfg_pkg::DATA_W'(imm);
            default:         result_next = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Output registers
    //////////////////////////////////////////////////////////////////////

    // One cycle from load to a valid result
    always_ff @(posedge clock) begin
        if (reset) begin
            result <= '0;
            zero   <= 1'b0;
        end else if (load) begin
            result <= result_next;
            zero   <= (result_next == '0);
        end
    end

    // Opcode must be resolved whenever a result is captured
    a_op_known: assert property (
        @(posedge clock) disable iff (reset)
        load |-> !$isunknown(op)
    ) else $error("alu: unknown opcode on load");

endmodule

// File: logic/exec_ctrl.sv
// Execute engine controller
// Four-phase req/ack FSM; sequences read, compute and write-back per command

`timescale 1ns/1ps

module exec_ctrl (
    input  logic                                      clock,
    input  logic                                      reset,

    // Host handshake
    input  logic                                      req,
    input  isa_pkg::exec_cmd_t                        cmd,
    output logic                                      ack,
    output isa_pkg::exec_rsp_t                        rsp,

    // Register file
    output logic [1:0]                                rf_re,
    output logic [1:0][cfg_pkg::REG_ADDR_W-1:0]       rf_raddr,
    input  logic [1:0][cfg_pkg::DATA_W-1:0]           rf_rdata,
    output logic                                      rf_we,
    output logic [cfg_pkg::REG_ADDR_W-1:0]            rf_waddr,
    output logic [cfg_pkg::DATA_W-1:0]                rf_wdata,

    // ALU
    output logic                                      alu_load,
    output isa_pkg::opcode_e                          alu_op,
    output logic [cfg_pkg::DATA_W-1:0]                alu_a,
    output logic [cfg_pkg::DATA_W-1:0]                alu_b,
    output logic [isa_pkg::IMM_W-1:0]                 alu_imm,
    input  logic [cfg_pkg::DATA_W-1:0]                alu_result,
    input  logic                                      alu_zero
);

    typedef enum logic [1:0] {
        IDLE = 2'd0,                                // Waiting for req
        EXEC = 2'd1,                                // Read sources, ALU computes
        WB   = 2'd2,                                // Write back, load response
        HOLD = 2'd3                                 // ack high until req drops
    } state_e;

    state_e              state;
    state_e              state_next;
    isa_pkg::exec_cmd_t  cmd_q;                     // Command in flight
    isa_pkg::exec_rsp_t  rsp_q;

    //////////////////////////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            IDLE:    if (req) state_next = EXEC;
            EXEC:    state_next = WB;
            WB:      state_next = HOLD;
            HOLD:    if (!req) state_next = IDLE;   // Host finished its phase
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
            ack   <= 1'b0;
            rsp_q <= '0;
        end else begin
            state <= state_next;
            if (state == WB) begin
                ack          <= 1'b1;               // Same edge as the write
                rsp_q.result <= alu_result;
                rsp_q.zero   <= alu_zero;
            end else if ((state == HOLD) && !req) begin
                ack <= 1'b0;
            end
        end
    end

    // Keeps rd and sources stable after the host lets go of cmd
    always_ff @(posedge clock) begin
        if ((state == IDLE) && req) begin
            cmd_q <= cmd;
        end
    end

    assign rsp = rsp_q;

    //////////////////////////////////////////////////////////////////////
    // Register file and ALU drive
    //////////////////////////////////////////////////////////////////////

    // LDI ignores both sources, so skip the reads
    assign rf_re       = ((state == EXEC) && (cmd_q.opcode != isa_pkg::OP_LDI)) ? 2'b11 : 2'b00;
    assign rf_raddr[0] = cmd_q.rs1;
    assign rf_raddr[1] = cmd_q.rs2;

    assign alu_load = (state == EXEC);              // Result valid at next edge
    assign alu_op   = cmd_q.opcode;
    assign alu_a    = rf_rdata[0];
    assign alu_b    = rf_rdata[1];
    assign alu_imm  = cmd_q.imm;

    assign rf_we    = (state == WB);
    assign rf_waddr = cmd_q.rd;
    assign rf_wdata = alu_result;

    //////////////////////////////////////////////////////////////////////
    // Assertions
    //////////////////////////////////////////////////////////////////////

    // Host still holding req keeps the response up
    a_ack_hold: assert property (
        @(posedge clock) disable iff (reset)
        (ack && req) |=> ack
    ) else $error("exec_ctrl: ack dropped while req high");

    // Write-back is the cycle just before ack rises
    a_we_in_wb: assert property (
        @(posedge clock) disable iff (reset)
        rf_we |=> (ack && !$past(ack))
    ) else $error("exec_ctrl: register write outside write-back");

endmodule

// File: logic/exec_top.sv
// Register-file execute engine top level
// Controller, two-read-port register file and registered ALU

`timescale 1ns/1ps

module exec_top (
    input  logic                clock,
    input  logic                reset,
    input  logic                req,
    input  isa_pkg::exec_cmd_t  cmd,
    output logic                ack,
    output isa_pkg::exec_rsp_t  rsp
);

    // Register file wiring
    logic [1:0]                                rf_re;
    logic [1:0][cfg_pkg::REG_ADDR_W-1:0]       rf_raddr;
    logic [1:0][cfg_pkg::DATA_W-1:0]           rf_rdata;
    logic                                      rf_we;
    logic [cfg_pkg::REG_ADDR_W-1:0]            rf_waddr;
    logic [cfg_pkg::DATA_W-1:0]                rf_wdata;

    // ALU wiring
    logic                                      alu_load;
    isa_pkg::opcode_e                          alu_op;
    logic [cfg_pkg::DATA_W-1:0]                alu_a;
    logic [cfg_pkg::DATA_W-1:0]                alu_b;
    logic [isa_pkg::IMM_W-1:0]                 alu_imm;
    logic [cfg_pkg::DATA_W-1:0]                alu_result;
    logic                                      alu_zero;

    exec_ctrl u_ctrl (
        .clock      (clock),
        .reset      (reset),
        .req        (req),
        .cmd        (cmd),
        .ack        (ack),
        .rsp        (rsp),
        .rf_re      (rf_re),
        .rf_raddr   (rf_raddr),
        .rf_rdata   (rf_rdata),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .alu_load   (alu_load),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_imm    (alu_imm),
        .alu_result (alu_result),
        .alu_zero   (alu_zero)
    );

    // Next command never overlaps a write, so no bypass
    mem_dp #(
        .WIDTH      (cfg_pkg::DATA_W),
        .DEPTH      (cfg_pkg::NUM_REGS),
        .READ_PORTS (2),
        .BYPASS_EN  (0)
    ) reg_file (
        .clock (clock),
        .reset (reset),
        .re    (rf_re),
        .raddr (rf_raddr),
        .rdata (rf_rdata),
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata)
    );

    alu u_alu (
        .clock  (clock),
        .reset  (reset),
        .load   (alu_load),
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .imm    (alu_imm),
        .result (alu_result),
        .zero   (alu_zero)
    );

endmodule

// File: testbench/tb_exec.sv
// Testbench for the register-file execute engine
// Four-phase host driver, reference model, response checker

`timescale 1ns/1ps

module tb_exec;

    localparam int TIMEOUT_CYCLES = 20;             // Per wait loop
    localparam int NUM_RANDOM     = 500;
    localparam int ACK_EDGES      = 4;              // Negedges from req drive to ack seen
    localparam int DROP_EDGES     = 2;              // Negedges from req drop to ack low
    localparam int DW             = cfg_pkg::DATA_W;

    logic                clock = 1'b0;
    logic                reset;
    logic                req;
    isa_pkg::exec_cmd_t  cmd;
    logic                ack;
    isa_pkg::exec_rsp_t  rsp;

    logic [DW-1:0]       model_regs [cfg_pkg::NUM_REGS];   // Expected register contents
    isa_pkg::exec_rsp_t  expected_q [$];            // One entry per command in flight
    int                  num_sent;
    int                  num_checked;
    logic                ack_prev;

    exec_top DUT (
        .clock (clock),
        .reset (reset),
        .req   (req),
        .cmd   (cmd),
        .ack   (ack),
        .rsp   (rsp)
    );

    always #5 clock = ~clock;                       // 10 ns period

    //////////////////////////////////////////////////////////////////////
    // Reference model and helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [DW-1:0] ref_result(
        input isa_pkg::opcode_e       op,
        input logic [DW-1:0]          a,
        input logic [DW-1:0]          b,
        input logic [isa_pkg::IMM_W-1:0] imm
    );
        logic [cfg_pkg::SHAMT_W-1:0] amount;
        logic [DW-1:0]               r;
        amount = b[cfg_pkg::SHAMT_W-1:0];           // Only low bits count
        r = a;
        case (op)
            isa_pkg::OP_ADD: r = a + b;
            isa_pkg::OP_SUB: r = a + ~b + DW'(1);   // Two's complement
            isa_pkg::OP_AND: r = a & b;
            isa_pkg::OP_OR:  r = a | b;
            isa_pkg::OP_XOR: r = a ^ b;
            isa_pkg::OP_SLL: begin
                for (int i = 0; i < int'(amount); i++) begin
                    r = {r[DW-2:0], 1'b0};          // One bit per step
                end
            end
            isa_pkg::OP_SRL: begin
                for (int i = 0; i < int'(amount); i++) begin
                    r = {1'b0, r[DW-1:1]};
                end
            end
            isa_pkg::OP_LDI: r = {{(DW - isa_pkg::IMM_W){1'b0}}, imm};
            default:         r = '0;
        endcase
        return r;
    endfunction

    function automatic isa_pkg::exec_cmd_t make_cmd(
        input isa_pkg::opcode_e          op,
        input int                        rd,
        input int                        rs1,
        input int                        rs2,
        input logic [isa_pkg::IMM_W-1:0] imm
    );
        isa_pkg::exec_cmd_t c;
        c.opcode = op;
        c.rd     = cfg_pkg::REG_ADDR_W'(rd);
        c.rs1    = cfg_pkg::REG_ADDR_W'(rs1);
        c.rs2    = cfg_pkg::REG_ADDR_W'(rs2);
        c.imm    = imm;
        return c;
    endfunction

    task automatic check_value(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timed out at %0t waiting for %s", $time, what);
        $display("Simulation failed");
        $fatal(1, "handshake timeout");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Host driver
    //////////////////////////////////////////////////////////////////////

    // Full four-phase exchange; model updated before the command goes out
    task automatic send_cmd(input isa_pkg::exec_cmd_t c, output isa_pkg::exec_rsp_t got);
        logic [DW-1:0]       r;
        isa_pkg::exec_rsp_t  exp_rsp;
        isa_pkg::exec_rsp_t  first_rsp;
        int                  waited;
        int                  extra;
        r = ref_result(c.opcode, model_regs[c.rs1], model_regs[c.rs2], c.imm);
        exp_rsp.result = r;
        exp_rsp.zero   = (r == '0);
        expected_q.push_back(exp_rsp);
        model_regs[c.rd] = r;
        num_sent++;

        @(posedge clock);
        req <= 1'b1;
        cmd <= c;
        waited = 0;
        do begin                                    // Wait for ack rise
            @(negedge clock);
            waited++;
        end while (!ack && (waited < TIMEOUT_CYCLES));
        if (!ack) stop_on_timeout("ack to rise");
        check_value(DW'(waited), DW'(ACK_EDGES), "req to ack latency");

        // Response must stay put under back-pressure
        first_rsp = rsp;
        extra = int'($urandom_range(5, 0));
        for (int i = 0; i < extra; i++) begin
            @(negedge clock);
            check_value(DW'(ack), DW'(1'b1), "ack during hold");
            check_value(rsp.result, first_rsp.result, "result during hold");
            check_value(DW'(rsp.zero), DW'(first_rsp.zero), "zero flag during hold");
        end

        @(posedge clock);
        req <= 1'b0;
        got = first_rsp;
        waited = 0;
        do begin                                    // Wait for ack fall
            @(negedge clock);
            waited++;
        end while (ack && (waited < TIMEOUT_CYCLES));
        if (ack) stop_on_timeout("ack to fall");
        check_value(DW'(waited), DW'(DROP_EDGES), "req drop to ack fall");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Response checker
    //////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        isa_pkg::exec_rsp_t exp_rsp;
        logic               rise;
        rise     = !reset && ack && !ack_prev;
        ack_prev = ack;
        if (rise) begin
            if (expected_q.size() == 0) begin
                $display("Response at %0t with no command outstanding", $time);
                $display("Simulation failed");
                $fatal(1, "unexpected ack");
            end else begin
                exp_rsp = expected_q.pop_front();
                check_value(rsp.result, exp_rsp.result, "result");
                check_value(DW'(rsp.zero), DW'(exp_rsp.zero), "zero flag");
                num_checked++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        isa_pkg::exec_rsp_t got;
        void'($urandom(32'h7a82bad5));
        reset <= 1'b1;
        req   <= 1'b0;
        cmd   <= '0;
        num_sent    = 0;
        num_checked = 0;
        ack_prev    = 1'b0;
        for (int i = 0; i < cfg_pkg::NUM_REGS; i++) begin
            model_regs[i] = '0;                     // Registers clear on reset
        end
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value(DW'(ack), '0, "ack after reset");

        // Everything reads zero out of reset
        send_cmd(make_cmd(isa_pkg::OP_ADD, 3, 5, 9, 16'h1234), got);
        check_value(got.result, '0, "ADD after reset");
        check_value(DW'(got.zero), DW'(1'b1), "zero flag after reset");

        // LDI then read back through OR
        send_cmd(make_cmd(isa_pkg::OP_LDI, 2, 0, 0, 16'hbeef), got);
        check_value(got.result, 32'h0000_beef, "LDI zero extension");
        send_cmd(make_cmd(isa_pkg::OP_OR, 4, 2, 2, 16'h0000), got);
        check_value(got.result, 32'h0000_beef, "OR readback");
        check_value(DW'(got.zero), '0, "OR zero flag");

        // Dependent chain
        send_cmd(make_cmd(isa_pkg::OP_LDI, 1, 0, 0, 16'h0007), got);
        send_cmd(make_cmd(isa_pkg::OP_ADD, 1, 1, 1, 16'h0000), got);
        check_value(got.result, 32'd14, "dependent ADD 1");
        send_cmd(make_cmd(isa_pkg::OP_ADD, 1, 1, 1, 16'h0000), got);
        check_value(got.result, 32'd28, "dependent ADD 2");
        send_cmd(make_cmd(isa_pkg::OP_XOR, 5, 1, 2, 16'h0000), got);
        check_value(got.result, 32'h0000_bef3, "dependent XOR");
        send_cmd(make_cmd(isa_pkg::OP_SUB, 5, 5, 5, 16'h0000), got);
        check_value(DW'(got.zero), DW'(1'b1), "SUB self zero flag");

        // Shift amounts and wrapping subtract
        send_cmd(make_cmd(isa_pkg::OP_LDI, 7, 0, 0, 16'h0001), got);
        send_cmd(make_cmd(isa_pkg::OP_LDI, 9, 0, 0, 16'h0023), got);   // 35 with low bits 3
        send_cmd(make_cmd(isa_pkg::OP_SLL, 8, 7, 9, 16'h0000), got);
        check_value(got.result, 32'h0000_0008, "SLL low shift bits");
        send_cmd(make_cmd(isa_pkg::OP_LDI, 11, 0, 0, 16'h0010), got);
        send_cmd(make_cmd(isa_pkg::OP_LDI, 10, 0, 0, 16'h8000), got);
        send_cmd(make_cmd(isa_pkg::OP_SLL, 10, 10, 11, 16'h0000), got);
        check_value(got.result, 32'h8000_0000, "SLL by 16");
        send_cmd(make_cmd(isa_pkg::OP_LDI, 13, 0, 0, 16'hffe1), got);  // Low bits 1
        send_cmd(make_cmd(isa_pkg::OP_SRL, 12, 10, 13, 16'h0000), got);
        check_value(got.result, 32'h4000_0000, "SRL logical");
        send_cmd(make_cmd(isa_pkg::OP_SUB, 14, 15, 7, 16'h0000), got);
        check_value(got.result, 32'hffff_ffff, "SUB wrap");

        // Random commands checked by the compare process
        for (int n = 0; n < NUM_RANDOM; n++) begin
            send_cmd(make_cmd(isa_pkg::opcode_e'(3'($urandom_range(7, 0))),
                              int'($urandom_range(15, 0)),
                              int'($urandom_range(15, 0)),
                              int'($urandom_range(15, 0)),
                              isa_pkg::IMM_W'($urandom)), got);
        end

        if ((num_checked != num_sent) || (expected_q.size() != 0)) begin
            $display("Only %0d of %0d responses were checked", num_checked, num_sent);
            $display("Simulation failed");
            $fatal(1, "missing responses");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// File: src.f
logic/cfg_pkg.sv
logic/isa_pkg.sv
logic/mem_dp.sv
logic/alu.sv
logic/exec_ctrl.sv
logic/exec_top.sv
testbench/tb_exec.sv

// File: Makefile
# Verilator simulation of the register-file execute engine
# Exit status of the sim target is the simulation result

VERILATOR ?= verilator
TOP       ?= tb_exec
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
JOBS      ?= 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
